//--- build.f
common/mhp_pkg.sv
hw/frame_buffer.sv
hw/frame_receiver.sv
reply/header_reader.sv
reply/reply_writer.sv
hw/frame_sender.sv
hw/mhp_top.sv
tb/tb_clock.sv
tb/tb_mhp.sv

//--- common/mhp_pkg.sv
package mhp_pkg;

  typedef logic [7:0] byte_t;

  // type byte, read whole or split into direction and command
  typedef union packed {
    byte_t raw;
    struct packed {
      logic       direction;
      logic [6:0] cmd;
    } f;
  } hdr_type_u;

  ////////////////////
  // command codes
  ////////////////////

  localparam logic [6:0] CMD_PING       = 7'd1;
  localparam logic [6:0] CMD_ADDR_GRANT = 7'd4;

  // ack flag inside cmd
  localparam int ACK_BIT = 4;

  ////////////////////
  // reply templates
  ////////////////////

  localparam byte_t       RSP_PING      = 8'h81;
  localparam byte_t       RSP_GRANT     = 8'h92;
  localparam logic [15:0] GRANT_PAYLOAD = 16'h0120;

  // payload bytes per reply type
  localparam int PING_PLEN  = 0;
  localparam int GRANT_PLEN = 2;

  ////////////////////
  // header layout
  ////////////////////

  localparam int HDR_LEN  = 7;
  localparam int OFS_SRC  = 0;
  localparam int OFS_DST  = 2;
  localparam int OFS_SIZE = 4;
  localparam int OFS_TYPE = 6;

endpackage

//--- hw/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer import mhp_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              i_clk,
  input  logic              i_we_rx,
  input  logic [ADDR_W-1:0] i_addr_rx,
  input  byte_t             i_wdata_rx,
  input  logic              i_we_rp,
  input  logic [ADDR_W-1:0] i_addr_rp,
  input  byte_t             i_wdata_rp,
  input  logic [ADDR_W-1:0] i_raddr_hdr,
  input  logic [ADDR_W-1:0] i_raddr_tx,
  output byte_t             o_rdata
);

  byte_t             mem [2**ADDR_W];
  logic              we;
  logic [ADDR_W-1:0] waddr;
  logic [ADDR_W-1:0] raddr;
  byte_t             wdata;

  // idle stages drive zero
  assign we    = i_we_rx | i_we_rp;
  assign waddr = i_addr_rx | i_addr_rp;
  assign wdata = i_wdata_rx | i_wdata_rp;
  assign raddr = i_raddr_hdr | i_raddr_tx;

  always_ff @(posedge i_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    o_rdata <= mem[raddr];
  end

  // receive and reply phases must not overlap
  a_one_writer: assert property (@(posedge i_clk) (i_we_rx & i_we_rp) !== 1'b1)
    else $error("receiver and reply writer both write the buffer");

endmodule

//--- hw/frame_receiver.sv
`timescale 1ns/10ps

module frame_receiver import mhp_pkg::*; #(
  parameter int ADDR_W         = 5,
  parameter int RX_IDLE_CYCLES = 63
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_rready,
  input  byte_t             i_rdata,
  input  logic              i_release,
  output logic              o_rreq,
  output logic              o_we,
  output logic [ADDR_W-1:0] o_addr,
  output byte_t             o_wdata,
  output logic              o_frame_end,
  output logic [ADDR_W:0]   o_frame_len
);

  localparam int GAP_W = $clog2(RX_IDLE_CYCLES + 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_REQ   = 2'd1;
  localparam logic [1:0] S_STORE = 2'd2;
  localparam logic [1:0] S_GAP   = 2'd3;

  logic [1:0]       state;
  logic             locked;
  logic [ADDR_W:0]  count;
  logic [GAP_W-1:0] gap_cnt;
  logic             gap_over;

  // msb set once the buffer is full
  assign o_rreq   = (state == S_REQ);
  assign o_we     = (state == S_STORE) && !count[ADDR_W];
  assign o_addr   = o_we ? count[ADDR_W-1:0] : '0;
  assign o_wdata  = o_we ? i_rdata : '0;
  assign gap_over = (state == S_GAP) && !i_rready && (gap_cnt == GAP_W'(RX_IDLE_CYCLES - 1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= S_IDLE;
      locked      <= 1'b0;
      count       <= '0;
      gap_cnt     <= '0;
      o_frame_end <= 1'b0;
    end else begin
      o_frame_end <= 1'b0;
      if (i_release) begin
        locked <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (i_rready && !locked) begin
            count <= '0;
            state <= S_REQ;
          end
        end
        S_REQ: state <= S_STORE;
        S_STORE: begin
          gap_cnt <= '0;
          if (!count[ADDR_W]) begin
            count <= count + 1'b1;
          end
          state <= S_GAP;
        end
        default: begin
          if (i_rready) begin
            state <= S_REQ;
          end else if (gap_over) begin
            o_frame_end <= 1'b1;
            locked      <= 1'b1;
            state       <= S_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (gap_over) begin
      o_frame_len <= count;
    end
  end

  a_rreq_pulse: assert property (@(posedge i_clk) disable iff (i_rst) o_rreq |=> !o_rreq)
    else $error("rreq held high on two consecutive cycles");

endmodule

//--- hw/frame_sender.sv
`timescale 1ns/10ps

module frame_sender import mhp_pkg::*; #(
  parameter int ADDR_W    = 5,
  parameter int REPLY_LEN = 16
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  logic [ADDR_W-1:0] i_reply_len,
  input  byte_t             i_rdata,
  input  logic              i_wready,
  output logic [ADDR_W-1:0] o_raddr,
  output byte_t             o_wdata,
  output logic              o_wvalid,
  output logic              o_done
);

  localparam int CNT_W = $clog2(REPLY_LEN);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_FETCH = 2'd1;
  localparam logic [1:0] S_SEND  = 2'd2;

  logic [1:0]       state;
  logic [CNT_W-1:0] idx;
  logic             hs;

  assign hs       = (state == S_SEND) && i_wready;
  assign o_wvalid = (state == S_SEND);
  // past the reply the tail is zero
  assign o_wdata  = (o_wvalid && (32'(idx) < 32'(i_reply_len))) ? i_rdata : '0;

  // next address goes out on the handshake, so data is ready a cycle later
  always_comb begin
    o_raddr = '0;
    if (state == S_FETCH) begin
      o_raddr = ADDR_W'(idx);
    end else if (state == S_SEND) begin
      o_raddr = hs ? ADDR_W'(idx + 1'b1) : ADDR_W'(idx);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          idx <= '0;
          if (i_start) begin
            state <= S_FETCH;
          end
        end
        S_FETCH: state <= S_SEND;
        S_SEND: begin
          if (hs && int'(idx) == REPLY_LEN - 1) begin
            o_done <= 1'b1;
            state  <= S_IDLE;
          end else if (hs) begin
            idx <= idx + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_hold_data: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wvalid && !i_wready |=> $stable(o_wdata))
    else $error("wdata changed while stalled by wready");

endmodule

//--- hw/mhp_top.sv
`timescale 1ns/10ps

module mhp_top import mhp_pkg::*; #(
  parameter int ADDR_W         = 5,
  parameter int RX_IDLE_CYCLES = 63,
  parameter int REPLY_LEN      = 16
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_rready,
  output logic  o_rreq,
  input  byte_t i_rdata,
  output byte_t o_wdata,
  output logic  o_wvalid,
  input  logic  i_wready,
  output logic  o_done
);

  ////////////////////
  // buffer ports
  ////////////////////

  logic              we_rx;
  logic [ADDR_W-1:0] addr_rx;
  byte_t             wdata_rx;
  logic              we_rp;
  logic [ADDR_W-1:0] addr_rp;
  byte_t             wdata_rp;
  logic [ADDR_W-1:0] raddr_hdr;
  logic [ADDR_W-1:0] raddr_tx;
  byte_t             rdata;

  ////////////////////
  // stage chain
  ////////////////////

  logic              frame_end;
  logic              hdr_done;
  logic [15:0]       src;
  logic [15:0]       dst;
  hdr_type_u         hdr_type;
  logic              reply_ready;
  logic              reply_drop;
  logic [ADDR_W-1:0] reply_len;
  logic              send_done;

  // finished either by a sent reply or a dropped frame
  assign o_done = send_done | reply_drop;

  frame_buffer #(.ADDR_W(ADDR_W)) u_buffer (
    .i_clk       (i_clk),
    .i_we_rx     (we_rx),
    .i_addr_rx   (addr_rx),
    .i_wdata_rx  (wdata_rx),
    .i_we_rp     (we_rp),
    .i_addr_rp   (addr_rp),
    .i_wdata_rp  (wdata_rp),
    .i_raddr_hdr (raddr_hdr),
    .i_raddr_tx  (raddr_tx),
    .o_rdata     (rdata)
  );

  frame_receiver #(.ADDR_W(ADDR_W), .RX_IDLE_CYCLES(RX_IDLE_CYCLES)) u_receiver (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rready    (i_rready),
    .i_rdata     (i_rdata),
    .i_release   (o_done),
    .o_rreq      (o_rreq),
    .o_we        (we_rx),
    .o_addr      (addr_rx),
    .o_wdata     (wdata_rx),
    .o_frame_end (frame_end),
    .o_frame_len ()
  );

  header_reader #(.ADDR_W(ADDR_W)) u_header (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (frame_end),
    .i_rdata    (rdata),
    .o_raddr    (raddr_hdr),
    .o_src      (src),
    .o_dst      (dst),
    .o_size     (),
    .o_type     (hdr_type),
    .o_hdr_done (hdr_done)
  );

  reply_writer #(.ADDR_W(ADDR_W)) u_writer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_start       (hdr_done),
    .i_src         (src),
    .i_dst         (dst),
    .i_type        (hdr_type),
    .o_we          (we_rp),
    .o_addr        (addr_rp),
    .o_wdata       (wdata_rp),
    .o_reply_ready (reply_ready),
    .o_reply_len   (reply_len),
    .o_reply_drop  (reply_drop)
  );

  frame_sender #(.ADDR_W(ADDR_W), .REPLY_LEN(REPLY_LEN)) u_sender (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (reply_ready),
    .i_reply_len (reply_len),
    .i_rdata     (rdata),
    .i_wready    (i_wready),
    .o_raddr     (raddr_tx),
    .o_wdata     (o_wdata),
    .o_wvalid    (o_wvalid),
    .o_done      (send_done)
  );

endmodule

//--- reply/header_reader.sv
`timescale 1ns/10ps

module header_reader import mhp_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  byte_t             i_rdata,
  output logic [ADDR_W-1:0] o_raddr,
  output logic [15:0]       o_src,
  output logic [15:0]       o_dst,
  output logic [15:0]       o_size,
  output hdr_type_u         o_type,
  output logic              o_hdr_done
);

  localparam int IDX_W = $clog2(HDR_LEN);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ADDR = 2'd1;
  localparam logic [1:0] S_LOAD = 2'd2;

  logic [1:0]       state;
  logic [IDX_W-1:0] idx;

  assign o_raddr = (state != S_IDLE) ? ADDR_W'(idx) : '0;

  // address one cycle, load the next
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= S_IDLE;
      idx        <= '0;
      o_hdr_done <= 1'b0;
    end else begin
      o_hdr_done <= 1'b0;
      case (state)
        S_IDLE: begin
          idx <= '0;
          if (i_start) begin
            state <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: begin
          if (int'(idx) == HDR_LEN - 1) begin
            o_hdr_done <= 1'b1;
            state      <= S_IDLE;
          end else begin
            idx   <= idx + 1'b1;
            state <= S_ADDR;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_LOAD) begin
      case (int'(idx))
        OFS_SRC:      o_src[15:8]  <= i_rdata;
        OFS_SRC + 1:  o_src[7:0]   <= i_rdata;
        OFS_DST:      o_dst[15:8]  <= i_rdata;
        OFS_DST + 1:  o_dst[7:0]   <= i_rdata;
        OFS_SIZE:     o_size[15:8] <= i_rdata;
        OFS_SIZE + 1: o_size[7:0]  <= i_rdata;
        default:      o_type.raw   <= i_rdata;
      endcase
    end
  end

endmodule

//--- reply/reply_writer.sv
`timescale 1ns/10ps

module reply_writer import mhp_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  logic [15:0]       i_src,
  input  logic [15:0]       i_dst,
  input  hdr_type_u         i_type,
  output logic              o_we,
  output logic [ADDR_W-1:0] o_addr,
  output byte_t             o_wdata,
  output logic              o_reply_ready,
  output logic [ADDR_W-1:0] o_reply_len,
  output logic              o_reply_drop
);

  logic              busy;
  logic              is_grant;
  logic              known;
  logic [ADDR_W-1:0] idx;
  logic [ADDR_W-1:0] ck_pos;
  logic [15:0]       csum;
  byte_t             cur;

  // acked frames and unknown commands get no reply
  assign known = !i_type.f.cmd[ACK_BIT] &&
                 ((i_type.f.cmd == CMD_PING) || (i_type.f.cmd == CMD_ADDR_GRANT));

  // checksum follows header and payload
  assign ck_pos = ADDR_W'(HDR_LEN + (is_grant ? GRANT_PLEN : PING_PLEN));

  assign o_we    = busy;
  assign o_addr  = busy ? idx : '0;
  assign o_wdata = busy ? cur : '0;

  ////////////////////
  // reply byte
  ////////////////////

  // addresses swap places, reply source is the received destination
  always_comb begin
    cur = '0;
    if (idx == ck_pos) begin
      cur = csum[15:8];
    end else if (idx == ck_pos + 1'b1) begin
      cur = csum[7:0];
    end else begin
      case (int'(idx))
        OFS_SRC:      cur = i_dst[15:8];
        OFS_SRC + 1:  cur = i_dst[7:0];
        OFS_DST:      cur = i_src[15:8];
        OFS_DST + 1:  cur = i_src[7:0];
        OFS_SIZE + 1: cur = is_grant ? 8'(GRANT_PLEN) : 8'(PING_PLEN);
        OFS_TYPE:     cur = is_grant ? RSP_GRANT : RSP_PING;
        HDR_LEN:      cur = GRANT_PAYLOAD[15:8];
        HDR_LEN + 1:  cur = GRANT_PAYLOAD[7:0];
        default:      cur = '0;
      endcase
    end
  end

  ////////////////////
  // write sequence
  ////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy          <= 1'b0;
      idx           <= '0;
      o_reply_ready <= 1'b0;
      o_reply_drop  <= 1'b0;
    end else begin
      o_reply_ready <= 1'b0;
      o_reply_drop  <= 1'b0;
      if (!busy) begin
        idx <= '0;
        if (i_start) begin
          busy         <= known;
          o_reply_drop <= !known;
        end
      end else begin
        idx <= idx + 1'b1;
        if (idx == ck_pos + 1'b1) begin
          busy          <= 1'b0;
          o_reply_ready <= 1'b1;
        end
      end
    end
  end

  // one byte per cycle, sum runs up to the checksum slot
  always_ff @(posedge i_clk) begin
    if (!busy) begin
      csum     <= '0;
      is_grant <= (i_type.f.cmd == CMD_ADDR_GRANT);
    end else if (idx < ck_pos) begin
      csum <= csum + 16'(cur);
    end
    if (busy && idx == ck_pos + 1'b1) begin
      o_reply_len <= idx + 1'b1;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mhp -f build.f -o tb_mhp_sim
out=$(./obj_dir/tb_mhp_sim)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD = 20,
  parameter int RST_CYCLES  = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // synchronous reset, released on an edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

//--- tb/tb_mhp.sv
`timescale 1ns/10ps

module tb_mhp import mhp_pkg::*;;

  localparam int IDLE_CYCLES  = 63;
  localparam int REPLY_LEN    = 16;
  localparam int RST_CYCLES   = 8;
  // longer than the idle gap, so frames stay apart
  localparam int PAUSE_CYCLES = 70;
  localparam int MAX_BYTES    = 40;
  localparam int FRAME_CYCLES = 3 * MAX_BYTES + PAUSE_CYCLES + IDLE_CYCLES + 40 + REPLY_LEN * 8;

  logic       clk;
  logic       rst;
  logic       i_rready;
  logic       o_rreq;
  byte_t      i_rdata;
  byte_t      o_wdata;
  logic       o_wvalid;
  logic       i_wready;
  logic       o_done;

  logic [8:0] rx_q [$];
  byte_t      exp_q [$];
  int         done_marks [$];
  logic [8:0] entry;
  byte_t      exp_byte;
  int         mark;
  int         pause_cnt;
  int         exp_total;
  int         n_frames;
  int         sent_cnt;
  int         done_cnt;
  int         mismatches;
  int         other_errs;
  integer     seed;
  bit         frames_loaded;

  tb_clock #(.HALF_PERIOD(20), .RST_CYCLES(RST_CYCLES)) u_clock (
    .o_clk (clk),
    .o_rst (rst)
  );

  mhp_top #(.ADDR_W(5), .RX_IDLE_CYCLES(IDLE_CYCLES), .REPLY_LEN(REPLY_LEN)) i_dut (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_rready (i_rready),
    .o_rreq   (o_rreq),
    .i_rdata  (i_rdata),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid),
    .i_wready (i_wready),
    .o_done   (o_done)
  );

  ////////////////////
  // frame and reference reply
  ////////////////////

  task automatic add_frame(input logic [15:0] src, input logic [15:0] dst,
                           input byte_t typ, input int extra);
    byte_t       reply [16];
    logic [15:0] sum;
    int          plen;
    bit          grant;
    bit          known;
    rx_q.push_back({1'b0, src[15:8]});
    rx_q.push_back({1'b0, src[7:0]});
    rx_q.push_back({1'b0, dst[15:8]});
    rx_q.push_back({1'b0, dst[7:0]});
    rx_q.push_back({1'b0, 8'(extra >> 8)});
    rx_q.push_back({1'b0, 8'(extra)});
    rx_q.push_back({extra == 0, typ});
    for (int j = 0; j < extra; j++)
      rx_q.push_back({j == extra - 1, 8'(j * 7 + 3)});
    // bit 4 of the command is the ack flag, bit 7 the direction
    grant = (typ[6:0] == 7'd4);
    known = !typ[4] && (grant || typ[6:0] == 7'd1);
    n_frames++;
    if (known) begin
      plen = grant ? 2 : 0;
      foreach (reply[i])
        reply[i] = 8'h00;
      reply[0] = dst[15:8];
      reply[1] = dst[7:0];
      reply[2] = src[15:8];
      reply[3] = src[7:0];
      reply[5] = 8'(plen);
      reply[6] = grant ? 8'h92 : 8'h81;
      if (grant) begin
        reply[7] = 8'h01;
        reply[8] = 8'h20;
      end
      sum = '0;
      for (int i = 0; i < 7 + plen; i++)
        sum = sum + 16'(reply[i]);
      reply[7 + plen] = sum[15:8];
      reply[8 + plen] = sum[7:0];
      foreach (reply[i])
        exp_q.push_back(reply[i]);
      exp_total += REPLY_LEN;
    end
    done_marks.push_back(exp_total);
  endtask

  // receive FIFO, one byte per request, data a cycle later
  always @(posedge clk) begin
    if (o_rreq) begin
      a_fifo_ready: assert (rx_q.size() != 0) else begin
        other_errs++;
        $display("rreq raised while the receive FIFO was empty");
      end
      if (rx_q.size() != 0) begin
        entry = rx_q.pop_front();
        i_rdata <= entry[7:0];
        if (entry[8])
          pause_cnt = PAUSE_CYCLES;
      end
    end else if (pause_cnt > 0) begin
      pause_cnt--;
    end
    i_rready <= (rx_q.size() != 0) && (pause_cnt == 0);
  end

  always @(posedge clk) begin
    i_wready <= (($random(seed) & 3) != 0);
  end

  ////////////////////
  // checks
  ////////////////////

  always @(posedge clk) begin
    if (!rst && o_wvalid && i_wready) begin
      sent_cnt++;
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("byte %h sent while no reply was expected", o_wdata);
      end else begin
        exp_byte = exp_q.pop_front();
        a_byte: assert (o_wdata === exp_byte) else begin
          mismatches++;
          $display("Mismatch: o_wdata byte %0d expected %h got %h",
                   sent_cnt - 1, exp_byte, o_wdata);
        end
      end
    end
    if (!rst && o_done) begin
      done_cnt++;
      if (done_marks.size() == 0) begin
        other_errs++;
        $display("o_done pulsed with no frame outstanding");
      end else begin
        mark = done_marks.pop_front();
        a_count: assert (sent_cnt == mark) else begin
          mismatches++;
          $display("Mismatch: bytes sent at o_done expected %h got %h", mark, sent_cnt);
        end
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !o_rreq && !o_wvalid && !o_done)
    else begin
      mismatches++;
      $display("Mismatch: o_rreq o_wvalid o_done after reset expected 0 0 0 got %h %h %h",
               o_rreq, o_wvalid, o_done);
    end

  a_rreq_once: assert property (@(posedge clk) disable iff (rst) o_rreq |=> !o_rreq)
    else begin
      other_errs++;
      $display("o_rreq stayed high for two cycles in a row");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata))
    else begin
      other_errs++;
      $display("o_wvalid or o_wdata changed while i_wready was low");
    end

  a_done_once: assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done)
    else begin
      other_errs++;
      $display("o_done stayed high for more than one cycle");
    end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [15:0] rs;
    logic [15:0] rd;
    byte_t       rt;
    int          extra;
    i_rready  = 1'b0;
    i_rdata   = '0;
    i_wready  = 1'b0;
    seed      = 32'h1c6;
    pause_cnt = 0;
    add_frame(16'h1234, 16'habcd, 8'h01, 0);
    add_frame(16'h0042, 16'h0007, 8'h04, 0);
    add_frame(16'h5555, 16'haaaa, 8'h11, 0);
    add_frame(16'h0102, 16'h0304, 8'h05, 2);
    add_frame(16'hfe01, 16'h10ef, 8'h81, 4);
    // overlong frame, tail dropped at the buffer end
    add_frame(16'h7788, 16'h99aa, 8'h04, MAX_BYTES - 7);
    for (int k = 0; k < 4; k++) begin
      rs    = 16'($random(seed));
      rd    = 16'($random(seed));
      extra = int'($unsigned($random(seed)) % 4);
      case ($unsigned($random(seed)) % 5)
        0: rt = 8'h01;
        1: rt = 8'h04;
        2: rt = 8'h84;
        3: rt = 8'h14;
        default: rt = 8'h02;
      endcase
      add_frame(rs, rd, rt, extra);
    end
    frames_loaded = 1'b1;
    wait (done_cnt == n_frames);
    repeat (20) @(posedge clk);
    a_drained: assert (exp_q.size() == 0) else begin
      other_errs++;
      $display("%0d expected reply bytes were never sent", exp_q.size());
    end
    $display("%0d frames, %0d bytes sent, %0d mismatches, %0d other errors",
             done_cnt, sent_cnt, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (frames_loaded);
    repeat (n_frames * FRAME_CYCLES + RST_CYCLES + 100) @(posedge clk);
    $display("timeout with %0d of %0d frames finished", done_cnt, n_frames);
    $display("Result: FAILED");
    $finish;
  end

endmodule
